//--- files.f
verilog/pm_pkg.sv
verilog/cycle_timer.sv
verilog/state_sequencer.sv
verilog/group_counter.sv
verilog/step_counter.sv
verilog/microop_decoder.sv
verilog/pm.sv
tests/pm_tb.sv

//--- run_sim.sh
#!/bin/sh
# run from the project root
verilator --binary --timing -Wno-fatal -f files.f --top-module pm_tb -o pm_sim \
	&& ./obj_dir/pm_sim > sim.log 2>&1 \
	|| echo "simulation did not complete"
cat sim.log
grep -q "^ALL CHECKS PASSED$" sim.log && echo "result: pass" || { echo "result: fail"; exit 1; }

//--- tests/pm_tb.sv
`timescale 1ns/100ps
`default_nettype none

module pm_tb;

	import pm_pkg::*;

	localparam int FRAME = 5;
	localparam int NRAND = 4;
	localparam int MAX_TESTS = 24;
	// each test gets 20 frames of 5 clocks
	localparam realtime LIMIT = MAX_TESTS * 20 * FRAME * 10;

	logic clk;
	logic reset;
	logic start_req;
	logic stop_req;
	logic irq;
	logic [15:0] ir;
	wire run;
	wire wait_cpu;
	wire [2:0] state;
	wire pp;
	wire w_ir;
	wire w_ar;
	wire w_ac;
	wire w_ic;
	wire w_r;
	wire [2:0] r_sel;
	wire [2:0] lg;
	wire [3:0] lk;

	int seed = 32'h70a2_150a;
	int errors = 0;
	int tests = 0;
	// per-test observations
	int n_p2;
	int n_p4;
	int n_p5;
	int n_pi;
	int n_pp;
	int n_wr;
	int n_wait;
	logic [4:0] seen;
	logic [2:0] last_rsel;

	pm #(
		.KC_TICKS(3),
		.PC_TICKS(2)
	) dut (
		.__clk(clk),
		.reset(reset),
		.start_req(start_req),
		.stop_req(stop_req),
		.irq(irq),
		.ir(ir),
		.run(run),
		.wait_cpu(wait_cpu),
		.state(state),
		.pp(pp),
		.w_ir(w_ir),
		.w_ar(w_ar),
		.w_ac(w_ac),
		.w_ic(w_ic),
		.w_r(w_r),
		.r_sel(r_sel),
		.lg(lg),
		.lk(lk)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		#(LIMIT);
		$display("timeout, the DUT never finished the instruction sequence");
		$display("CHECKS FAILED");
		$finish;
	end

	task check_val(input string name, input int got, input int exp);
		assert (got == exp) else begin
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	// expected frames and strobes straight from the instruction fields
	function automatic void ref_model(input logic [15:0] w, output int p5,
			output logic [4:0] mask, output int wr, output int rsel);
		logic [5:0] op;
		logic grp;
		int start;
		int cnt;
		op = w[15:10];
		start = int'(w[9:7]);
		cnt = int'(w[6:3]);
		grp = (op == OP_LRS) || (op == OP_SHC);
		if (op == OP_LRS)
			p5 = 8 - start;
		else if (op == OP_SHC)
			p5 = (cnt == 0) ? 1 : cnt;
		else
			p5 = 1;
		mask = {1'b1, !grp && w[9], op == OP_AW, op == OP_UJ, op == OP_LW || op == OP_LRS};
		wr = (op == OP_LRS) ? 8 - start : (op == OP_LW) ? 1 : 0;
		rsel = (op == OP_LRS) ? 7 : (op == OP_LW) ? int'(w[8:6]) : 0;
	endfunction

	task wait_state(input logic [2:0] s);
		do @(negedge clk); while (state != s);
	endtask

	// md prefixes and the word, followed until P1 again or P0
	task run_instr(input logic [15:0] w, input logic irq_v, input int md, input logic stop_v);
		int i;
		logic seen_p5;
		logic done;
		wait_state(ST_P1);
		for (i = 0; i < md; i++) begin
			@(posedge clk);
			#1 ir = {OP_MD, 10'h0};
			do @(negedge clk); while (!w_ir);
		end
		@(posedge clk);
		#1;
		ir = w;
		irq = irq_v;
		stop_req = stop_v;
		if (stop_v) begin
			@(posedge clk);
			#1 stop_req = 1'b0;
		end
		{n_p2, n_p4, n_p5, n_pi, n_pp, n_wr, n_wait} = '0;
		seen = '0;
		last_rsel = '0;
		seen_p5 = 1'b0;
		done = 1'b0;
		while (!done) begin
			@(negedge clk);
			seen |= {w_ir, w_ar, w_ac, w_ic, w_r};
			if (w_r) begin
				n_wr++;
				last_rsel = r_sel;
			end
			case (state)
				ST_P2: n_p2++;
				ST_P4: n_p4++;
				ST_P5: begin
					n_p5++;
					seen_p5 = 1'b1;
				end
				ST_PI: n_pi++;
				default: ;
			endcase
			if (pp)
				n_pp++;
			if (wait_cpu && !run)
				n_wait++;
			done = seen_p5 && (state == ST_P1 || (state == ST_P0 && !irq));
		end
		@(posedge clk);
		#1 irq = 1'b0;
	endtask

	task score_instr(input logic [15:0] w, input logic irq_v, input int md, input int p5,
			input logic [4:0] mask, input int wr, input int rsel);
		int err0;
		int lk_exp;
		err0 = errors;
		lk_exp = (w[6:3] == 4'h0) ? 0 : int'(w[6:3]) - 1;
		check_val("p5 clocks", n_p5, p5 * FRAME);
		check_val("strobe mask", int'(seen), int'(mask));
		check_val("w_r count", n_wr, wr);
		if (wr > 0)
			check_val("r_sel", int'(last_rsel), rsel);
		check_val("p4 clocks", n_p4, (md > 0) ? FRAME : 0);
		check_val("p2 visited", int'(n_p2 > 0), int'(mask[3]));
		check_val("pi clocks", n_pi, int'(irq_v) * FRAME);
		check_val("pp clocks", n_pp, int'(irq_v) * FRAME);
		check_val("wait_cpu seen", int'(n_wait > 0), int'(w[15:10] == OP_HLT));
		// counters hold their values from the last execute frame
		check_val("lg", int'(lg), (int'(w[9:7]) + p5 - 1) % 8);
		if (w[15:10] != OP_LRS)
			check_val("lk", int'(lk), lk_exp - (p5 - 1));
		tests++;
		$display("test %0d word %h irq %0d md %0d: %s", tests, w, irq_v, md,
			(errors == err0) ? "ok" : "errors");
	endtask

	initial begin
		int fd;
		int n;
		int w;
		int iv;
		int ep5;
		int em;
		int ewr;
		int ers;
		int md;
		int mp5;
		int mwr;
		int mrs;
		int i;
		int r;
		int nvec;
		logic [4:0] mmask;
		logic [15:0] word;
		string line;
		reset = 1'b1;
		start_req = 1'b0;
		stop_req = 1'b0;
		irq = 1'b0;
		ir = '0;
		nvec = 0;
		repeat (3) @(posedge clk);
		#1 reset = 1'b0;
		@(negedge clk);
		check_val("state", int'(state), int'(ST_P0));
		check_val("run", int'(run), 0);
		check_val("strobes", int'({w_ir, w_ar, w_ac, w_ic, w_r}), 0);
		@(posedge clk);
		#1 start_req = 1'b1;
		@(posedge clk);
		#1 start_req = 1'b0;

		fd = $fopen("tests/pm_vectors.txt", "r");
		if (fd == 0) begin
			$display("could not open the vector file");
			errors++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				r = $fgets(line, fd);
				n = 0;
				if (line.len() > 0 && line[0] != "#")
					n = $sscanf(line, "%h %d %d %h %d %d %d", w, iv, ep5, em, ewr, ers, md);
				if (n == 7) begin
					word = w[15:0];
					nvec++;
					// vector file must agree with the model
					ref_model(word, mp5, mmask, mwr, mrs);
					check_val("vector p5", ep5, mp5);
					check_val("vector mask", em, int'(mmask));
					check_val("vector w_r count", ewr, mwr);
					check_val("vector r_sel", ers, mrs);
					run_instr(word, iv[0], md, 1'b0);
					score_instr(word, iv[0], md, ep5, em[4:0], ewr, ers);
				end
			end
			$fclose(fd);
			if (nvec == 0) begin
				$display("no test vectors were read from the vector file");
				errors++;
			end
		end

		// extra group and shift words
		for (i = 0; i < NRAND; i++) begin
			r = $random(seed);
			if (i % 2 == 0)
				word = {OP_LRS, r[2:0], 7'h0};
			else
				word = {OP_SHC, 3'h0, r[3:0], 3'h0};
			ref_model(word, mp5, mmask, mwr, mrs);
			run_instr(word, 1'b0, 0, 1'b0);
			score_instr(word, 1'b0, 0, mp5, mmask, mwr, mrs);
		end

		// instruction still completes after a stop during fetch
		word = {OP_AW, 10'h0};
		ref_model(word, mp5, mmask, mwr, mrs);
		run_instr(word, 1'b0, 0, 1'b1);
		score_instr(word, 1'b0, 0, mp5, mmask, mwr, mrs);
		check_val("state after stop", int'(state), int'(ST_P0));
		check_val("run after stop", int'(run), 0);

		$display("%0d tests, %0d errors", tests, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- tests/pm_vectors.txt
# word(hex) irq p5_frames strobe_mask(hex: w_ir w_ar w_ac w_ic w_r) w_r_count last_r_sel md
# md is the number of premodification prefixes before the word
4140 0 1 11 1 5 0
4610 0 1 1c 0 0 0
4800 0 1 12 0 0 0
5180 0 5 11 5 7 0
5000 0 8 11 8 7 0
5420 0 4 10 0 0 0
5400 0 1 10 0 0 0
4400 0 1 14 0 0 2
4040 0 1 11 1 1 3
4400 0 1 14 0 0 0
4800 1 1 12 0 0 0
5800 1 1 10 0 0 0
41c0 0 1 11 1 7 0

//--- verilog/cycle_timer.sv
`timescale 1ns/100ps
`default_nettype none

module cycle_timer #(
	parameter int KC_TICKS = 3,
	parameter int PC_TICKS = 2
) (
	input wire __clk,
	input wire reset,
	output logic kc,
	output logic pc
);

	localparam int MAX_TICKS = (KC_TICKS > PC_TICKS) ? KC_TICKS : PC_TICKS;
	localparam int CNT_W = $clog2(MAX_TICKS) + 1;

	localparam logic [CNT_W-1:0] KC_LOAD = CNT_W'(KC_TICKS - 1);
	localparam logic [CNT_W-1:0] PC_LOAD = CNT_W'(PC_TICKS - 1);

	// one down-counter shared by both intervals
	logic [CNT_W-1:0] cnt;
	// 0: cycle-end interval, 1: cycle-start interval
	logic phase;

	always_ff @(posedge __clk) begin
		if (reset) begin
			cnt <= KC_LOAD;
			phase <= 1'b0;
			kc <= 1'b0;
			pc <= 1'b0;
		end else begin
			kc <= 1'b0;
			pc <= 1'b0;
			if (cnt == '0) begin
				if (!phase) begin
					// end of cycle, start interval follows
					kc <= 1'b1;
					cnt <= PC_LOAD;
					phase <= 1'b1;
				end else begin
					pc <= 1'b1;
					cnt <= KC_LOAD;
					phase <= 1'b0;
				end
			end else begin
				cnt <= cnt - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/group_counter.sv
`timescale 1ns/100ps
`default_nettype none

module group_counter (
	input wire __clk,
	input wire reset,
	input wire lg_load,
	input wire lg_inc,
	input wire [pm_pkg::RS_W-1:0] start_reg,
	output logic [pm_pkg::RS_W-1:0] lg,
	output logic lg_last
);

	import pm_pkg::*;

	localparam logic [RS_W-1:0] LAST_REG = '1;

	always_ff @(posedge __clk) begin
		if (reset) begin
			lg <= '0;
		end else if (lg_load) begin
			// first register of the group
			lg <= start_reg;
		end else if (lg_inc) begin
			lg <= lg + 1'b1;
		end
	end

	// group always ends at r7
	assign lg_last = (lg == LAST_REG);

endmodule

`default_nettype wire

//--- verilog/microop_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module microop_decoder (
	input wire __clk,
	input wire reset,
	input wire kc,
	input wire [pm_pkg::ST_W-1:0] state,
	input var pm_pkg::instr_word_t ir_q,
	input wire [pm_pkg::RS_W-1:0] lg,
	input wire lk_zero,
	input wire lg_last,
	output logic w_ir,
	output logic w_ar,
	output logic w_ac,
	output logic w_ic,
	output logic w_r,
	output logic [pm_pkg::RS_W-1:0] r_sel
);

	import pm_pkg::*;

	logic end_p5;
	logic last_frame;
	logic lrs_op;
	logic lw_op;
	logic r_write;

	assign end_p5 = kc && (state == ST_P5);
	assign last_frame = last_exec_frame(ir_q, lk_zero, lg_last);
	assign lrs_op = (ir_q.n.op == OP_LRS);
	assign lw_op = (ir_q.n.op == OP_LW);

	// group load writes a register every frame, LW only once
	assign r_write = end_p5 && (lrs_op || (lw_op && last_frame));

	always_ff @(posedge __clk) begin
		if (reset) begin
			w_ir <= 1'b0;
			w_ar <= 1'b0;
			w_ac <= 1'b0;
			w_ic <= 1'b0;
			w_r <= 1'b0;
		end else begin
			w_ir <= kc && (state == ST_P1);
			w_ar <= kc && (state == ST_P2);
			w_ac <= end_p5 && last_frame && (ir_q.n.op == OP_AW);
			w_ic <= end_p5 && last_frame && (ir_q.n.op == OP_UJ);
			w_r <= r_write;
		end
	end

	// register select follows the strobe
	always_ff @(posedge __clk) begin
		if (r_write)
			r_sel <= lrs_op ? lg : ir_q.n.a;
	end

endmodule

`default_nettype wire

//--- verilog/pm.sv
`timescale 1ns/100ps
`default_nettype none

module pm #(
	parameter int KC_TICKS = 3,
	parameter int PC_TICKS = 2
) (
	input wire __clk,
	input wire reset,
	input wire start_req,
	input wire stop_req,
	input wire irq,
	input wire [pm_pkg::IR_W-1:0] ir,
	output wire run,
	output wire wait_cpu,
	output wire [pm_pkg::ST_W-1:0] state,
	output wire pp,
	output wire w_ir,
	output wire w_ar,
	output wire w_ac,
	output wire w_ic,
	output wire w_r,
	output wire [pm_pkg::RS_W-1:0] r_sel,
	output wire [pm_pkg::RS_W-1:0] lg,
	output wire [pm_pkg::LK_W-1:0] lk
);

	import pm_pkg::*;

	wire kc;
	instr_word_t ir_q;
	wire lg_load;
	wire lg_inc;
	wire lk_load;
	wire lk_dec;
	wire lg_last;
	wire lk_zero;

	// cycle start pulse only paces the timer itself
	cycle_timer #(
		.KC_TICKS(KC_TICKS),
		.PC_TICKS(PC_TICKS)
	) u_timer (
		.__clk(__clk),
		.reset(reset),
		.kc(kc),
		.pc()
	);

	state_sequencer u_seq (
		.__clk(__clk),
		.reset(reset),
		.kc(kc),
		.start_req(start_req),
		.stop_req(stop_req),
		.irq(irq),
		.ir(ir),
		.lg_last(lg_last),
		.lk_zero(lk_zero),
		.state(state),
		.ir_q(ir_q),
		.lg_load(lg_load),
		.lg_inc(lg_inc),
		.lk_load(lk_load),
		.lk_dec(lk_dec),
		.run(run),
		.wait_cpu(wait_cpu),
		.pp(pp)
	);

	group_counter u_lg (
		.__clk(__clk),
		.reset(reset),
		.lg_load(lg_load),
		.lg_inc(lg_inc),
		.start_reg(ir_q.g.start),
		.lg(lg),
		.lg_last(lg_last)
	);

	step_counter u_lk (
		.__clk(__clk),
		.reset(reset),
		.lk_load(lk_load),
		.lk_dec(lk_dec),
		.count(ir_q.g.count),
		.lk(lk),
		.lk_zero(lk_zero)
	);

	microop_decoder u_dec (
		.__clk(__clk),
		.reset(reset),
		.kc(kc),
		.state(state),
		.ir_q(ir_q),
		.lg(lg),
		.lk_zero(lk_zero),
		.lg_last(lg_last),
		.w_ir(w_ir),
		.w_ar(w_ar),
		.w_ac(w_ac),
		.w_ic(w_ic),
		.w_r(w_r),
		.r_sel(r_sel)
	);

endmodule

`default_nettype wire

//--- verilog/pm_pkg.sv
`default_nettype none

package pm_pkg;

	// word and field widths
	localparam int IR_W = 16;
	localparam int ST_W = 3;
	localparam int OP_W = 6;
	localparam int RS_W = 3;
	localparam int LK_W = 4;

	// main loop states
	localparam logic [ST_W-1:0] ST_P0 = 3'd0;
	localparam logic [ST_W-1:0] ST_P1 = 3'd1;
	localparam logic [ST_W-1:0] ST_P2 = 3'd2;
	localparam logic [ST_W-1:0] ST_P3 = 3'd3;
	localparam logic [ST_W-1:0] ST_P4 = 3'd4;
	localparam logic [ST_W-1:0] ST_P5 = 3'd5;
	localparam logic [ST_W-1:0] ST_PI = 3'd6;

	// opcodes
	localparam logic [OP_W-1:0] OP_LW  = 6'h10;
	localparam logic [OP_W-1:0] OP_AW  = 6'h11;
	localparam logic [OP_W-1:0] OP_UJ  = 6'h12;
	localparam logic [OP_W-1:0] OP_MD  = 6'h13;
	localparam logic [OP_W-1:0] OP_LRS = 6'h14;
	localparam logic [OP_W-1:0] OP_SHC = 6'h15;
	localparam logic [OP_W-1:0] OP_HLT = 6'h16;

	// one instruction word, two formats
	typedef union packed {
		struct packed {
			logic [OP_W-1:0] op;
			logic d;
			logic [RS_W-1:0] a;
			logic [RS_W-1:0] b;
			logic [RS_W-1:0] c;
		} n;
		struct packed {
			logic [OP_W-1:0] op;
			logic [RS_W-1:0] start;
			logic [LK_W-1:0] count;
			logic [2:0] spare;
		} g;
	} instr_word_t;

	// P5 ends the instruction unless a shift or group op still has frames left
	function automatic logic last_exec_frame(
		input instr_word_t w,
		input logic lk_zero,
		input logic lg_last
	);
		logic shc_more;
		logic lrs_more;
		shc_more = (w.n.op == OP_SHC) && !lk_zero;
		lrs_more = (w.n.op == OP_LRS) && !lg_last;
		return !(shc_more || lrs_more);
	endfunction

endpackage

`default_nettype wire

//--- verilog/state_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module state_sequencer (
	input wire __clk,
	input wire reset,
	input wire kc,
	input wire start_req,
	input wire stop_req,
	input wire irq,
	input var pm_pkg::instr_word_t ir,
	input wire lg_last,
	input wire lk_zero,
	output logic [pm_pkg::ST_W-1:0] state,
	output pm_pkg::instr_word_t ir_q,
	output logic lg_load,
	output logic lg_inc,
	output logic lk_load,
	output logic lk_dec,
	output logic run,
	output logic wait_cpu,
	output logic pp
);

	import pm_pkg::*;

	logic start_q;
	logic [1:0] mc;
	logic [ST_W-1:0] state_nxt;
	logic [ST_W-1:0] after_b;
	logic [ST_W-1:0] after_d;
	instr_word_t cur;
	logic is_group;
	logic last_p5;
	logic p5_enter;
	logic p5_repeat;

	// during fetch the word is decoded straight from the bus
	assign cur = (state == ST_P1) ? ir : ir_q;
	assign is_group = (cur.n.op == OP_LRS) || (cur.n.op == OP_SHC);
	assign last_p5 = last_exec_frame(ir_q, lk_zero, lg_last);

	// argument chain, group ops carry no d or b field
	assign after_b = (mc != 2'd0) ? ST_P4 : ST_P5;
	assign after_d = (!is_group && cur.n.b != '0) ? ST_P3 : after_b;

	always_comb begin
		state_nxt = state;
		case (state)
			ST_P0: begin
				if (start_q && irq)
					state_nxt = ST_PI;
				else if (run)
					state_nxt = ST_P1;
			end
			ST_P1: begin
				if (cur.n.op == OP_MD)
					state_nxt = ST_P1;
				else if (!is_group && cur.n.d)
					state_nxt = ST_P2;
				else
					state_nxt = after_d;
			end
			ST_P2: state_nxt = after_d;
			ST_P3: state_nxt = after_b;
			ST_P4: state_nxt = ST_P5;
			ST_P5: begin
				if (!last_p5)
					state_nxt = ST_P5;
				else if (!start_q || ir_q.n.op == OP_HLT)
					state_nxt = ST_P0;
				else if (irq)
					state_nxt = ST_PI;
				else
					state_nxt = ST_P1;
			end
			ST_PI: state_nxt = run ? ST_P1 : ST_P0;
			default: state_nxt = ST_P0;
		endcase
	end

	assign p5_enter = kc && (state != ST_P5) && (state_nxt == ST_P5);
	assign p5_repeat = kc && (state == ST_P5) && (state_nxt == ST_P5);

	always_ff @(posedge __clk) begin
		if (reset) begin
			state <= ST_P0;
			start_q <= 1'b0;
			wait_cpu <= 1'b0;
			mc <= 2'd0;
			lg_load <= 1'b0;
			lg_inc <= 1'b0;
			lk_load <= 1'b0;
			lk_dec <= 1'b0;
		end else begin
			// stop has priority over start
			if (stop_req)
				start_q <= 1'b0;
			else if (start_req)
				start_q <= 1'b1;

			// counter controls land in the first clock of the new frame
			lg_load <= p5_enter;
			lk_load <= p5_enter;
			lg_inc <= p5_repeat;
			lk_dec <= p5_repeat;

			if (state == ST_PI)
				wait_cpu <= 1'b0;
			else if (kc && state == ST_P5 && last_p5 && ir_q.n.op == OP_HLT)
				wait_cpu <= 1'b1;

			if (kc) begin
				state <= state_nxt;
				if (state == ST_P1 && cur.n.op == OP_MD && mc != 2'd3)
					mc <= mc + 2'd1;
				else if (state == ST_P4)
					mc <= 2'd0;
			end
		end
	end

	// instruction register
	always_ff @(posedge __clk) begin
		if (kc && state == ST_P1)
			ir_q <= ir;
	end

	assign run = start_q && !wait_cpu;
	assign pp = (state == ST_PI);

endmodule

`default_nettype wire

//--- verilog/step_counter.sv
`timescale 1ns/100ps
`default_nettype none

module step_counter (
	input wire __clk,
	input wire reset,
	input wire lk_load,
	input wire lk_dec,
	input wire [pm_pkg::LK_W-1:0] count,
	output logic [pm_pkg::LK_W-1:0] lk,
	output logic lk_zero
);

	import pm_pkg::*;

	logic [LK_W-1:0] load_val;

	// a zero count still takes one step
	assign load_val = (count == '0) ? '0 : count - 1'b1;

	always_ff @(posedge __clk) begin
		if (reset) begin
			lk <= '0;
		end else if (lk_load) begin
			lk <= load_val;
		end else if (lk_dec && !lk_zero) begin
			lk <= lk - 1'b1;
		end
	end

	assign lk_zero = (lk == '0);

endmodule

`default_nettype wire
